// File: files.f
+incdir+.
audipus_regs_pkg.sv
audipus_panel_pkg.sv
spi_slave.sv
sys_registers.sv
rotary_encoder.sv
stepper_drive.sv
audipus_control.sv
tb_audipus_control.sv

// File: Makefile
TOP = tb_audipus_control

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_audipus_control.sv
`default_nettype none

`include "audipus_settings.svh"

module tb_audipus_control
    import audipus_regs_pkg::*;
();

    // ~65 spi frames of ~280 cycles plus encoder and motor idle time with ample margin
    localparam int CYCLE_LIMIT = 60000;

    logic       clk;
    logic       reset;
    logic       spi_cs0_n;
    logic       spi_clk;
    logic       spi_mosi;
    logic [1:0] spi_cs_sel;
    logic       pcm_int0;
    logic       pcm_int1;
    logic       dac_zero_l;
    logic       dac_zero_r;
    logic       pwr_supply_int;
    logic       encoder_a;
    logic       encoder_b;
    logic       encoder_sw;
    logic       spi_miso;
    logic       spi_cs_pcm9211_n;
    logic       spi_cs_pcm1792_n;
    logic       spi_cs_lcd_n;
    logic       irq;
    logic [3:0] step_drv;

    int          errors = 0;        // main flow
    int          cs_errors = 0;     // select monitor
    int          cycle = 0;
    logic [31:0] rng = 32'hf9e8;
    logic [3:0]  last_drv = 4'b0000;
    logic [3:0]  chg_val [$];       // step_drv after each change
    int          chg_cyc [$];       // cycle of that change
    logic [7:0]  model_motor = 8'h00;
    logic [7:0]  model_scratch = 8'h00;
    logic [4:0]  model_irq = 5'h00;
    logic [6:0]  model_count = 7'h00;
    logic        model_sw = 1'b0;

    audipus_control i_dut (
        .clk(clk), .reset(reset), .spi_cs0_n(spi_cs0_n), .spi_clk(spi_clk),
        .spi_mosi(spi_mosi), .spi_cs_sel(spi_cs_sel), .pcm_int0(pcm_int0),
        .pcm_int1(pcm_int1), .dac_zero_l(dac_zero_l), .dac_zero_r(dac_zero_r),
        .pwr_supply_int(pwr_supply_int), .encoder_a(encoder_a), .encoder_b(encoder_b),
        .encoder_sw(encoder_sw), .spi_miso(spi_miso),
        .spi_cs_pcm9211_n(spi_cs_pcm9211_n), .spi_cs_pcm1792_n(spi_cs_pcm1792_n),
        .spi_cs_lcd_n(spi_cs_lcd_n), .irq(irq), .step_drv(step_drv)
    );

    //////////////////////////////
    // reference models
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [7:0] reg_model(input logic [6:0] addr);
        case (addr)
            REG_ID:      return `AUD_ID;
            REG_STATUS:  return {2'b00, model_sw, 5'b00000};   // sources idle
            REG_IRQ:     return {3'b000, model_irq};
            REG_MOTOR:   return model_motor;
            REG_ENCODER: return {model_sw, model_count};
            REG_SCRATCH: return model_scratch;
            default:     return 8'h00;
        endcase
    endfunction

    function automatic logic [6:0] enc_model(input logic [6:0] count, input logic fwd);
        return fwd ? count + 7'd1 : count - 7'd1;   // 7 bit wrap
    endfunction

    // {a, b} at each point of the forward walk
    function automatic logic [1:0] gray_of(input logic [1:0] pos);
        case (pos)
            2'd0:    return 2'b00;
            2'd1:    return 2'b01;
            2'd2:    return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    // phase a on bit 0 and forward moves one bit up
    function automatic logic [3:0] step_model(input logic [3:0] drv, input logic fwd);
        return fwd ? {drv[2:0], drv[3]} : {drv[0], drv[3:1]};
    endfunction

    // {lcd, pcm1792, pcm9211}
    function automatic logic [2:0] cs_model(input logic cs0_n, input logic [1:0] sel);
        if (cs0_n) return 3'b111;
        case (sel)
            2'b01:   return 3'b110;
            2'b10:   return 3'b101;
            2'b11:   return 3'b011;
            default: return 3'b111;     // fpga owns the bus
        endcase
    endfunction

    //////////////////////////////
    // mode 0 spi host with 8 clk per level
    task automatic spi_frame(input logic [15:0] frame, output logic [7:0] rx);
        rx = 8'h00;
        spi_cs_sel = 2'b00;
        spi_cs0_n  = 1'b0;
        repeat (8) @(negedge clk);
        for (int i = 15; i >= 0; i--) begin
            spi_mosi = frame[i];
            repeat (8) @(negedge clk);
            spi_clk = 1'b1;
            if (i < 8) rx = {rx[6:0], spi_miso};   // second byte carries read data
            repeat (8) @(negedge clk);
            spi_clk = 1'b0;
        end
        repeat (8) @(negedge clk);
        spi_cs0_n = 1'b1;
        repeat (8) @(negedge clk);
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused_rx;
        spi_frame({OP_WRITE, addr, data}, unused_rx);
    endtask

    task automatic spi_read(input logic [6:0] addr, output logic [7:0] data);
        spi_frame({OP_READ, addr, 8'h00}, data);
    endtask

    task automatic read_expect(input logic [6:0] addr, input string name);
        logic [7:0] exp;
        logic [7:0] got;
        exp = reg_model(addr);      // taken before the read clears anything
        spi_read(addr, got);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // walk the recorded changes of one motor run
    task automatic check_steps(input int base, input logic fwd, input int period,
                               input logic start_known, input logic [3:0] start_val,
                               output logic [3:0] held);
        int         n;
        logic [3:0] exp;
        n    = chg_val.size() - base;
        held = 4'b0000;
        if (n < 3) begin
            $display("motor run recorded only %0d changes of step_drv", n);
            errors++;
        end else begin
            if (!$onehot(chg_val[base]) || (start_known && chg_val[base] !== start_val)) begin
                $display("[ERROR] step_drv on enable: got %h, expected %h",
                         chg_val[base], start_val);
                errors++;
            end
            for (int i = base + 1; i < base + n - 1; i++) begin
                exp = step_model(chg_val[i-1], fwd);
                if (chg_val[i] !== exp) begin
                    $display("[ERROR] step_drv: got %h, expected %h", chg_val[i], exp);
                    errors++;
                end
                if (chg_cyc[i] - chg_cyc[i-1] != period) begin
                    $display("[ERROR] step spacing: got %h, expected %h",
                             chg_cyc[i] - chg_cyc[i-1], period);
                    errors++;
                end
            end
            if (chg_val[base+n-1] !== 4'b0000) begin
                $display("[ERROR] step_drv on disable: got %h, expected %h",
                         chg_val[base+n-1], 4'b0000);
                errors++;
            end
            held = chg_val[base+n-2];
        end
    endtask

    //////////////////////////////
    // clock with watchdog and monitors
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == CYCLE_LIMIT) begin
            $display("timeout, run still going after %0d clk cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // selects are combinational so compared every cycle
    always @(posedge clk) begin
        if (!reset && {spi_cs_lcd_n, spi_cs_pcm1792_n, spi_cs_pcm9211_n}
                      !== cs_model(spi_cs0_n, spi_cs_sel)) begin
            $display("[ERROR] spi selects: got %h, expected %h",
                     {spi_cs_lcd_n, spi_cs_pcm1792_n, spi_cs_pcm9211_n},
                     cs_model(spi_cs0_n, spi_cs_sel));
            cs_errors <= cs_errors + 1;
        end
    end

    always @(negedge clk) begin
        if (step_drv !== last_drv) begin
            chg_val.push_back(step_drv);
            chg_cyc.push_back(cycle);
        end
        last_drv <= step_drv;
    end

    //////////////////////////////
    // test flow
    initial begin : main_flow
        logic [6:0] addr;
        logic [7:0] data;
        logic [4:0] subset;
        logic [1:0] pos;
        logic       fwd;
        logic [5:0] iv;
        int         period;
        int         base;
        logic [3:0] held;
        logic [3:0] held_rev;
        reset = 1'b1;
        spi_cs0_n = 1'b1;
        spi_clk = 1'b0;
        spi_mosi = 1'b0;
        spi_cs_sel = 2'b00;
        {pwr_supply_int, dac_zero_l, dac_zero_r, pcm_int1, pcm_int0} = 5'b00000;
        encoder_a = 1'b0;
        encoder_b = 1'b0;
        encoder_sw = 1'b1;      // released
        pos = 2'd0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        // reset values and id
        if (step_drv !== 4'b0000) begin
            $display("[ERROR] step_drv: got %h, expected %h", step_drv, 4'b0000);
            errors++;
        end
        if (irq !== 1'b0) begin
            $display("[ERROR] irq: got %h, expected %h", irq, 1'b0);
            errors++;
        end
        read_expect(REG_ID, "id");

        // scratch and motor read back
        for (int i = 0; i < 20; i++) begin
            rng  = xorshift32(rng);
            addr = rng[0] ? REG_SCRATCH : REG_MOTOR;
            data = rng[15:8];
            spi_write(addr, data);
            if (addr == REG_SCRATCH) model_scratch = data;
            else model_motor = data;
            read_expect(addr, "scratch/motor");
        end
        rng = xorshift32(rng);
        spi_write(REG_ID, rng[7:0]);    // must not stick
        read_expect(REG_ID, "id after write");
        // writable bytes untouched by the id write
        read_expect(REG_SCRATCH, "scratch after id write");
        read_expect(REG_MOTOR, "motor after id write");
        for (int i = 0; i < 4; i++) begin
            rng  = xorshift32(rng);
            addr = 7'(32'd6 + rng % 32'd122);
            read_expect(addr, "unmapped");
        end

        // chip select decode checked by the select monitor
        for (int s = 0; s < 4; s++) begin
            spi_cs_sel = 2'(s);
            spi_cs0_n  = 1'b0;
            repeat (3) @(negedge clk);
            spi_cs0_n  = 1'b1;
            repeat (3) @(negedge clk);
        end
        spi_cs_sel = 2'b00;

        // interrupt flags
        for (int r = 0; r < 3; r++) begin
            rng    = xorshift32(rng);
            subset = (rng[4:0] == 5'b0) ? 5'b00001 : rng[4:0];
            {pwr_supply_int, dac_zero_l, dac_zero_r, pcm_int1, pcm_int0} = subset;
            repeat (2) @(negedge clk);
            {pwr_supply_int, dac_zero_l, dac_zero_r, pcm_int1, pcm_int0} = 5'b00000;
            repeat (6) @(negedge clk);
            if (irq !== 1'b1) begin
                $display("[ERROR] irq: got %h, expected %h", irq, 1'b1);
                errors++;
            end
            model_irq = subset;
            read_expect(REG_IRQ, "irq flags");
            model_irq = 5'b00000;   // cleared by that read
            read_expect(REG_IRQ, "irq after clear");
            if (irq !== 1'b0) begin
                $display("[ERROR] irq: got %h, expected %h", irq, 1'b0);
                errors++;
            end
        end

        // encoder walk
        for (int k = 0; k < 30; k++) begin
            rng = xorshift32(rng);
            fwd = rng[3];
            pos = fwd ? pos + 2'd1 : pos - 2'd1;
            {encoder_a, encoder_b} = gray_of(pos);
            model_count = enc_model(model_count, fwd);
            repeat (`ENC_DEBOUNCE + 20) @(negedge clk);
        end
        read_expect(REG_ENCODER, "encoder count");
        model_count = 7'h00;
        read_expect(REG_ENCODER, "encoder after clear");
        encoder_sw = 1'b0;      // press
        model_sw   = 1'b1;
        repeat (`ENC_DEBOUNCE + 20) @(negedge clk);
        read_expect(REG_STATUS, "status with switch");
        read_expect(REG_ENCODER, "encoder with switch");
        encoder_sw = 1'b1;
        model_sw   = 1'b0;
        repeat (`ENC_DEBOUNCE + 20) @(negedge clk);

        // stepper forward then reverse from the held phase
        rng    = xorshift32(rng);
        iv     = 6'(32'd1 + rng % 32'd3);
        period = (int'(iv) + 1) * `STEP_TICK;
        spi_write(REG_MOTOR, 8'h00);
        repeat (16) @(negedge clk);
        base = chg_val.size();
        spi_write(REG_MOTOR, {iv, 2'b01});
        while (chg_val.size() - base < 8) @(negedge clk);
        spi_write(REG_MOTOR, 8'h00);
        repeat (16) @(negedge clk);
        check_steps(base, 1'b1, period, 1'b0, 4'b0000, held);
        base = chg_val.size();
        spi_write(REG_MOTOR, {iv, 2'b11});
        while (chg_val.size() - base < 8) @(negedge clk);
        spi_write(REG_MOTOR, 8'h00);
        repeat (16) @(negedge clk);
        check_steps(base, 1'b0, period, 1'b1, held, held_rev);

        $display("run finished with %0d errors (%0d flow, %0d chip select)",
                 errors + cs_errors, errors, cs_errors);
        if (errors + cs_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: audipus_control.sv
`default_nettype none

module audipus_control (
    input  wire       clk,
    input  wire       reset,
    input  wire       spi_cs0_n,        // shared host chip select
    input  wire       spi_clk,
    input  wire       spi_mosi,
    input  wire [1:0] spi_cs_sel,       // which device owns cs0
    input  wire       pcm_int0,
    input  wire       pcm_int1,
    input  wire       dac_zero_l,
    input  wire       dac_zero_r,
    input  wire       pwr_supply_int,
    input  wire       encoder_a,
    input  wire       encoder_b,
    input  wire       encoder_sw,       // active low on the panel
    output logic      spi_miso,         // board gates it with the fpga select
    output logic      spi_cs_pcm9211_n,
    output logic      spi_cs_pcm1792_n,
    output logic      spi_cs_lcd_n,
    output logic      irq,
    output logic [3:0] step_drv
);

    logic       spi_cs_fpga_n;
    logic [6:0] reg_addr;
    logic [7:0] reg_wr_data;
    logic       reg_wr_stb;
    logic       reg_rd_stb;
    logic [7:0] rd_data;
    logic [4:0] irq_src;
    logic [6:0] enc_count;
    logic       enc_sw;
    logic       enc_clear;
    logic       motor_enable;
    logic       motor_reverse;
    logic [5:0] motor_interval;

    //////////////////////////////
    // chip select decode
    assign spi_cs_fpga_n    = spi_cs0_n | (spi_cs_sel != 2'b00);
    assign spi_cs_pcm9211_n = spi_cs0_n | (spi_cs_sel != 2'b01);  // s/pdif receiver
    assign spi_cs_pcm1792_n = spi_cs0_n | (spi_cs_sel != 2'b10);  // dac
    assign spi_cs_lcd_n     = spi_cs0_n | (spi_cs_sel != 2'b11);

    // irq bit order as seen in the status and irq registers
    assign irq_src = {pwr_supply_int, dac_zero_l, dac_zero_r, pcm_int1, pcm_int0};

    //////////////////////////////
    // host link and registers
    spi_slave spi_if (
        .clk         (clk),
        .reset       (reset),
        .cs_n        (spi_cs_fpga_n),
        .sclk        (spi_clk),
        .mosi        (spi_mosi),
        .rd_data     (rd_data),
        .miso        (spi_miso),
        .reg_addr    (reg_addr),
        .reg_wr_data (reg_wr_data),
        .reg_wr_stb  (reg_wr_stb),
        .reg_rd_stb  (reg_rd_stb)
    );

    sys_registers sys_reg (
        .clk            (clk),
        .reset          (reset),
        .reg_addr       (reg_addr),
        .reg_wr_data    (reg_wr_data),
        .reg_wr_stb     (reg_wr_stb),
        .reg_rd_stb     (reg_rd_stb),
        .irq_src        (irq_src),
        .enc_count      (enc_count),
        .enc_sw         (enc_sw),
        .rd_data        (rd_data),
        .irq            (irq),
        .enc_clear      (enc_clear),
        .motor_enable   (motor_enable),
        .motor_reverse  (motor_reverse),
        .motor_interval (motor_interval)
    );

    //////////////////////////////
    // front panel and motor
    rotary_encoder rot_enc (
        .clk      (clk),
        .reset    (reset),
        .enc_a    (encoder_a),
        .enc_b    (encoder_b),
        .enc_sw_n (encoder_sw),
        .clear    (enc_clear),
        .count    (enc_count),
        .sw       (enc_sw)
    );

    stepper_drive step_drive (
        .clk      (clk),
        .reset    (reset),
        .enable   (motor_enable),
        .reverse  (motor_reverse),
        .interval (motor_interval),
        .step_drv (step_drv)
    );

endmodule

`default_nettype wire

// File: stepper_drive.sv
`default_nettype none

`include "audipus_settings.svh"

module stepper_drive
    import audipus_panel_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        enable,
    input  wire        reverse,
    input  wire  [5:0] interval,    // period is (interval + 1) ticks
    output logic [3:0] step_drv     // one coil per bit
);

    localparam int TICK_W = $clog2(`STEP_TICK);

    logic [TICK_W-1:0] tick_cnt;
    logic [5:0]        unit_cnt;
    logic              tick_end;
    logic              step_now;
    step_phase_e       phase;

    //////////////////////////////
    // interval timer
    assign tick_end = (tick_cnt == TICK_W'(`STEP_TICK - 1));
    assign step_now = enable && tick_end && (unit_cnt >= interval);  // >= covers a shrunk interval

    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            tick_cnt <= '0;     // period starts over on enable
            unit_cnt <= '0;
        end else if (tick_end) begin
            tick_cnt <= '0;
            unit_cnt <= (unit_cnt >= interval) ? 6'd0 : unit_cnt + 6'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // phase is kept across a disable
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_A;
        end else if (step_now) begin
            phase <= reverse ? step_phase_e'(phase - 2'd1) : step_phase_e'(phase + 2'd1);
        end
    end

    assign step_drv = enable ? (4'b0001 << phase) : 4'b0000;  // coils off when idle

    a_one_coil : assert property (@(posedge clk) disable iff (reset) $onehot0(step_drv));

endmodule

`default_nettype wire

// File: rotary_encoder.sv
`default_nettype none

`include "audipus_settings.svh"

module rotary_encoder
    import audipus_panel_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        enc_a,
    input  wire        enc_b,
    input  wire        enc_sw_n,    // low while pressed
    input  wire        clear,       // host read of the count
    output logic [6:0] count,       // signed, wraps
    output logic       sw
);

    localparam int DB_W = $clog2(`ENC_DEBOUNCE);

    logic [2:0]      pin_s1;        // {sw_n, b, a}
    logic [2:0]      pin_s2;
    logic [2:0]      pin_db;        // debounced copy
    logic [DB_W-1:0] db_cnt [3];
    enc_state_e      state_q;
    enc_state_e      state_now;
    logic            step_fwd;
    logic            step_rev;

    // next state going forward
    function automatic enc_state_e fwd_of(enc_state_e s);
        case (s)
            ENC_00:  return ENC_01;
            ENC_01:  return ENC_11;
            ENC_11:  return ENC_10;
            default: return ENC_00;
        endcase
    endfunction

    // next state going backward
    function automatic enc_state_e rev_of(enc_state_e s);
        case (s)
            ENC_00:  return ENC_10;
            ENC_10:  return ENC_11;
            ENC_11:  return ENC_01;
            default: return ENC_00;
        endcase
    endfunction

    //////////////////////////////
    // sync and debounce
    always_ff @(posedge clk) begin
        if (reset) begin
            pin_s1 <= 3'b100;   // switch released
            pin_s2 <= 3'b100;
        end else begin
            pin_s1 <= {enc_sw_n, enc_b, enc_a};
            pin_s2 <= pin_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pin_db <= 3'b100;
            for (int i = 0; i < 3; i++) begin
                db_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (pin_s2[i] == pin_db[i]) begin
                    db_cnt[i] <= '0;            // bounce restarts the wait
                end else if (db_cnt[i] == DB_W'(`ENC_DEBOUNCE - 1)) begin
                    db_cnt[i] <= '0;
                    pin_db[i] <= pin_s2[i];     // held long enough
                end else begin
                    db_cnt[i] <= db_cnt[i] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // quadrature decode
    assign state_now = enc_state_e'({pin_db[0], pin_db[1]});
    assign step_fwd  = (state_now == fwd_of(state_q));
    assign step_rev  = (state_now == rev_of(state_q));  // double jumps count nothing

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ENC_00;
            count   <= '0;
        end else begin
            state_q <= state_now;
            if (clear) begin
                count <= '0;
            end else if (step_fwd) begin
                count <= count + 7'd1;
            end else if (step_rev) begin
                count <= count - 7'd1;
            end
        end
    end

    assign sw = ~pin_db[2];

endmodule

`default_nettype wire

// File: sys_registers.sv
`default_nettype none

`include "audipus_settings.svh"

module sys_registers
    import audipus_regs_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire  [6:0] reg_addr,
    input  wire  [7:0] reg_wr_data,
    input  wire        reg_wr_stb,
    input  wire        reg_rd_stb,
    input  wire  [4:0] irq_src,     // raw pins from the board
    input  wire  [6:0] enc_count,
    input  wire        enc_sw,
    output logic [7:0] rd_data,
    output logic       irq,
    output logic       enc_clear,
    output logic       motor_enable,
    output logic       motor_reverse,
    output logic [5:0] motor_interval
);

    logic [4:0] src_s1;
    logic [4:0] src_s2;     // live synced level, shown in status
    logic [4:0] src_prev;
    logic [4:0] irq_flags;
    logic       irq_clear;
    logic [7:0] motor_reg;
    logic [7:0] scratch_reg;
    logic [7:0] rd_mux;

    //////////////////////////////
    // interrupt sources
    always_ff @(posedge clk) begin
        if (reset) begin
            src_s1    <= '0;
            src_s2    <= '0;
            src_prev  <= '0;
            irq_flags <= '0;
        end else begin
            src_s1   <= irq_src;
            src_s2   <= src_s1;
            src_prev <= src_s2;
            // new rising edge survives a clear landing in the same cycle
            irq_flags <= (irq_clear ? 5'd0 : irq_flags) | (src_s2 & ~src_prev);
        end
    end

    assign irq = |irq_flags;

    //////////////////////////////
    // host writes
    always_ff @(posedge clk) begin
        if (reset) begin
            motor_reg   <= '0;
            scratch_reg <= '0;
        end else if (reg_wr_stb) begin
            case (reg_addr)
                REG_MOTOR:   motor_reg   <= reg_wr_data;
                REG_SCRATCH: scratch_reg <= reg_wr_data;
                default: ;  // id, status, irq and encoder are read only
            endcase
        end
    end

    assign motor_enable   = motor_reg[0];
    assign motor_reverse  = motor_reg[1];
    assign motor_interval = motor_reg[7:2];

    //////////////////////////////
    // read back
    always_comb begin
        case (reg_addr)
            REG_ID:      rd_mux = `AUD_ID;
            REG_STATUS:  rd_mux = {2'b00, enc_sw, src_s2};
            REG_IRQ:     rd_mux = {3'b000, irq_flags};
            REG_MOTOR:   rd_mux = motor_reg;
            REG_ENCODER: rd_mux = {enc_sw, enc_count};
            REG_SCRATCH: rd_mux = scratch_reg;
            default:     rd_mux = 8'h00;    // unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data   <= '0;
            enc_clear <= 1'b0;
            irq_clear <= 1'b0;
        end else begin
            if (reg_rd_stb) begin
                rd_data <= rd_mux;
            end
            // clear pulses follow the capture by one cycle
            enc_clear <= reg_rd_stb && (reg_addr == REG_ENCODER);
            irq_clear <= reg_rd_stb && (reg_addr == REG_IRQ);
        end
    end

    // writes to read only addresses leave the writable bytes alone
    a_ro_write : assert property (@(posedge clk) disable iff (reset)
        reg_wr_stb && (reg_addr == REG_ID || reg_addr == REG_STATUS ||
                       reg_addr == REG_ENCODER)
        |=> $stable(motor_reg) && $stable(scratch_reg));

endmodule

`default_nettype wire

// File: spi_slave.sv
`default_nettype none

module spi_slave
    import audipus_regs_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        cs_n,
    input  wire        sclk,
    input  wire        mosi,
    input  wire  [7:0] rd_data,     // from the register file, one cycle after rd strobe
    output logic       miso,
    output logic [6:0] reg_addr,
    output logic [7:0] reg_wr_data,
    output logic       reg_wr_stb,
    output logic       reg_rd_stb
);

    logic [1:0] cs_q;       // two flop sync
    logic [2:0] sclk_q;     // two flop sync plus one for edges
    logic [1:0] mosi_q;
    logic       active;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [4:0] bit_cnt;    // rising edges seen this frame, stops at 16
    logic [6:0] shift_in;
    logic [7:0] byte_in;
    logic       first_done;
    logic       second_done;
    spi_op_e    op_q;
    logic [1:0] rd_dly;     // spaces the read strobe from the address byte
    logic       rd_load;
    logic [7:0] tx_shift;

    //////////////////////////////
    // pin sync and edge detect
    always_ff @(posedge clk) begin
        if (reset) begin
            cs_q   <= 2'b11;    // idle deselected
            sclk_q <= 3'b000;
            mosi_q <= 2'b00;
        end else begin
            cs_q   <= {cs_q[0], cs_n};
            sclk_q <= {sclk_q[1:0], sclk};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign active    = ~cs_q[1];
    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];

    // byte as it stands with the current bit shifted in
    assign byte_in     = {shift_in, mosi_q[1]};
    assign first_done  = active && sclk_rise && (bit_cnt == 5'd7);
    assign second_done = active && sclk_rise && (bit_cnt == 5'd15);

    //////////////////////////////
    // receive side
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (!active) begin
            bit_cnt <= '0;      // frame over or never started
        end else if (sclk_rise && bit_cnt != 5'd16) begin
            bit_cnt <= bit_cnt + 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            shift_in <= byte_in[6:0];   // msb first
        end
        if (first_done) begin
            reg_addr <= byte_in[6:0];
            op_q     <= spi_op_e'(byte_in[7]);
        end
        if (second_done) begin
            reg_wr_data <= byte_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_dly     <= 2'b00;
            reg_rd_stb <= 1'b0;
            rd_load    <= 1'b0;
            reg_wr_stb <= 1'b0;
        end else begin
            rd_dly     <= {rd_dly[0], first_done && (spi_op_e'(byte_in[7]) == OP_READ)};
            reg_rd_stb <= rd_dly[1];    // third cycle after the 8th edge
            rd_load    <= reg_rd_stb;   // rd_data is registered by now
            reg_wr_stb <= second_done && (op_q == OP_WRITE);
        end
    end

    //////////////////////////////
    // transmit side
    // msb sits on miso once loaded, later falling edges move the next bit up
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_shift <= 8'h00;
        end else if (rd_load) begin
            tx_shift <= rd_data;
        end else if (active && sclk_fall && bit_cnt > 5'd8) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign miso = tx_shift[7];

    // only one frame at a time so the two strobes never meet
    a_one_strobe : assert property (@(posedge clk) disable iff (reset)
        !(reg_wr_stb && reg_rd_stb));

endmodule

`default_nettype wire

// File: audipus_panel_pkg.sv
`default_nettype none

package audipus_panel_pkg;

    //////////////////////////////
    // debounced encoder pair {a, b}
    // forward walk is 00 -> 01 -> 11 -> 10 -> 00
    typedef enum logic [1:0] {
        ENC_00 = 2'b00,     // detent rest on most panels
        ENC_01 = 2'b01,
        ENC_11 = 2'b11,
        ENC_10 = 2'b10
    } enc_state_e;

    //////////////////////////////
    // stepper coil phase, one coil on at a time
    typedef enum logic [1:0] {
        PH_A = 2'd0,        // step_drv[0]
        PH_B = 2'd1,
        PH_C = 2'd2,
        PH_D = 2'd3         // step_drv[3]
    } step_phase_e;

endpackage

`default_nettype wire

// File: audipus_regs_pkg.sv
`default_nettype none

package audipus_regs_pkg;

    //////////////////////////////
    // host visible register map
    // 7 bit address from the low bits of the first spi byte
    typedef enum logic [6:0] {
        REG_ID      = 7'h00,    // read only id byte
        REG_STATUS  = 7'h01,    // live interrupt pins and encoder switch
        REG_IRQ     = 7'h02,    // latched flags, cleared by reading
        REG_MOTOR   = 7'h03,    // {interval[5:0], reverse, enable}
        REG_ENCODER = 7'h04,    // {sw, count[6:0]}, count cleared by reading
        REG_SCRATCH = 7'h05     // free byte for the host
    } reg_addr_e;

    //////////////////////////////
    // opcode bit
    // msb of the first byte, sent first on mosi
    typedef enum logic {
        OP_WRITE = 1'b0,        // second byte is write data
        OP_READ  = 1'b1         // second byte carries read data on miso
    } spi_op_e;

endpackage

`default_nettype wire

// File: audipus_settings.svh
`ifndef AUDIPUS_SETTINGS_SVH
`define AUDIPUS_SETTINGS_SVH

//////////////////////////////
// board constants for the control block

// value read back from the id register
`define AUD_ID 8'hA5

// clk cycles an encoder pin has to stay put
// before the debounced copy follows it
`define ENC_DEBOUNCE 16

// clk cycles per unit of the motor interval field
// one step every (interval + 1) * STEP_TICK cycles
`define STEP_TICK 8

`endif
